/* Bender.yml */
package:
  name: uart_rx

sources:
  - common/uart_rx_pkg.sv
  - common/rx_frame_if.sv
  - verilog/rx_filter.sv
  - rx_framer/rx_framer.sv
  - verilog/rx_status.sv
  - verilog/uart_rx.sv
  - target: test
    files:
      - dv/uart_rx_checker.sv
      - dv/tb_uart_rx.sv

/* common/rx_frame_if.sv */
/*
 * finished-frame interface from the framer to the status block
 * all signals are single-clock pulses or values valid with them
 */
`timescale 1ns/1ns
`default_nettype none

interface rx_frame_if;

  logic               byte_done;   // last data or parity bit sampled
  uart_rx_pkg::byte_t data;        // valid with byte_done
  logic               parity_bad;  // valid with byte_done, low without parity
  logic               stop_bad;    // stop bit sampled low

  modport framer (
    output byte_done,
    output data,
    output parity_bad,
    output stop_bad
  );

  modport status (
    input byte_done,
    input data,
    input parity_bad,
    input stop_bad
  );

endinterface

`default_nettype wire

/* common/uart_rx_pkg.sv */
/*
 * uart receiver shared definitions
 * byte type, bit counter type, receive state encoding and the
 * default oversampling ratio
 */
`default_nettype none

package uart_rx_pkg;

  // one received data byte, bit 7 is zero in 7-bit mode
  typedef logic [7:0] byte_t;

  // counts data plus parity bits of one frame, up to 9
  typedef logic [3:0] bit_cnt_t;

  // receive state machine
  typedef enum logic [1:0] {
    RX_IDLE = 2'd0,  // hunting for a start bit
    RX_DATA = 2'd1,  // shifting in data and parity
    RX_STOP = 2'd2,  // checking the stop bit
    RX_WAIT = 2'd3   // waiting for the line to return high
  } rx_state_e;

  // baud_tick strobes per serial bit
  localparam int OVERSAMPLE_DEFAULT = 16;

endpackage

`default_nettype wire

/* dv/tb_uart_rx.sv */
/*
 * uart receiver testbench
 * clock, reset, baud tick divider, serial frame driver and test sequence
 */
`timescale 1ns/1ns
`default_nettype none

module tb_uart_rx;

  localparam int OVERSAMPLE = uart_rx_pkg::OVERSAMPLE_DEFAULT;
  localparam int BAUD_DIV   = 3;                  // clocks per baud_tick
  localparam int SEED       = 32'h2db6;
  localparam int NUM_FRAMES = 23;
  localparam int BIT_CLKS   = OVERSAMPLE * BAUD_DIV;
  localparam int GLITCH_AT  = BIT_CLKS / 2 - 1;   // glitch sits mid bit
  localparam int MAX_CYCLES = NUM_FRAMES * 14 * BIT_CLKS + 2000;

  logic               clk;
  logic               aresetn;
  logic               baud_tick;
  logic               rx;
  logic               bit8;
  logic               parity_en;
  logic               odd_n_even;
  logic               read_rx_byte;
  logic               clear_parity;
  logic               clear_framing_error;
  uart_rx_pkg::byte_t rx_byte;
  logic               receive_full;
  logic               overflow;
  logic               parity_err;
  logic               framing_error;

  logic        frame_sent;  // one clock per frame, with sent_info
  logic [12:0] sent_info;   // data, bit8, parity_en, odd, bad parity, stop
  int          baud_cnt;
  int          cycles;
  int          frames;
  int          mismatches;
  int          other_errors;
  int          pending;

  uart_rx #(.OVERSAMPLE(OVERSAMPLE)) DUT (.*);

  uart_rx_checker u_checker (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // baud tick, one clock in BAUD_DIV
  always @(negedge clk)
  begin
    if (baud_cnt == BAUD_DIV - 1)
    begin
      baud_cnt  <= 0;
      baud_tick <= 1'b1;
    end
    else
    begin
      baud_cnt  <= baud_cnt + 1;
      baud_tick <= 1'b0;
    end
  end

  task automatic print_summary();
    $display("frames %0d, mismatches %0d, other errors %0d, unread frames %0d",
             frames, mismatches, other_errors, pending);
  endtask

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: run still going after %0d clock cycles", cycles);
      print_summary();
      $display(">>> FAIL");
      $finish;
    end
  end

  // --------------------
  // serial driver
  // --------------------
  task automatic drive_bit(input logic value, input logic glitch);
    for (int i = 0; i < BIT_CLKS; i++)
    begin
      @(negedge clk);
      if (glitch && (i >= GLITCH_AT) && (i < GLITCH_AT + BAUD_DIV))
        rx = 1'b0;  // low for exactly one tick
      else
        rx = value;
    end
  endtask

  task automatic send_frame(input uart_rx_pkg::byte_t data, input logic bad_par,
                            input logic stop_val, input logic glitch);
    int   nbits;
    logic pbit;
    nbits = bit8 ? 8 : 7;
    pbit  = (^(data & (bit8 ? 8'hff : 8'h7f))) ^ odd_n_even ^ bad_par;
    if (glitch)
      drive_bit(1'b1, 1'b1);  // glitch on the idle line first
    @(negedge clk);
    sent_info  = {data, bit8, parity_en, odd_n_even, bad_par, stop_val};
    frame_sent = 1'b1;
    @(negedge clk);
    frame_sent = 1'b0;
    frames++;
    drive_bit(1'b0, 1'b0);  // start bit
    for (int i = 0; i < nbits; i++)
      drive_bit(data[i], glitch);  // lsb first
    if (parity_en)
      drive_bit(pbit, 1'b0);
    drive_bit(stop_val, 1'b0);
    drive_bit(1'b1, 1'b0);
    drive_bit(1'b1, 1'b0);
  endtask

  task automatic host_read();
    @(negedge clk);
    read_rx_byte = 1'b1;
    @(negedge clk);
    read_rx_byte = 1'b0;
    clear_parity = 1'b1;
    @(negedge clk);
    clear_parity        = 1'b0;
    clear_framing_error = 1'b1;
    @(negedge clk);
    clear_framing_error = 1'b0;
  endtask

  task automatic set_format(input logic b8, input logic pe, input logic odd);
    @(negedge clk);
    bit8       = b8;
    parity_en  = pe;
    odd_n_even = odd;
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial
  begin
    void'($urandom(SEED));
    {baud_cnt, cycles, frames} = '0;
    {baud_tick, read_rx_byte, clear_parity, clear_framing_error} = '0;
    {bit8, parity_en, odd_n_even, frame_sent, sent_info} = '0;
    rx      = 1'b1;
    aresetn = 1'b0;
    repeat (4) @(negedge clk);
    aresetn = 1'b1;
    repeat (2 * BIT_CLKS) @(negedge clk);

    for (int fmt = 0; fmt < 4; fmt++)  // clean frames, every format
      for (int n = 0; n < 3; n++)
      begin
        set_format(fmt[1], fmt[0], $urandom % 2);
        send_frame($urandom, 1'b0, 1'b1, 1'b0);
        host_read();
      end
    for (int n = 0; n < 4; n++)  // wrong parity, odd and even
    begin
      set_format(n[1], 1'b1, n[0]);
      send_frame($urandom, 1'b1, 1'b1, 1'b0);
      host_read();
    end
    set_format(1'b1, 1'b0, 1'b0);  // low stop bit
    send_frame($urandom, 1'b0, 1'b0, 1'b0);
    host_read();
    set_format(1'b0, 1'b1, 1'b0);
    send_frame($urandom, 1'b0, 1'b0, 1'b0);
    host_read();
    set_format(1'b1, 1'b1, 1'b1);  // two frames, one read
    send_frame($urandom, 1'b0, 1'b1, 1'b0);
    send_frame($urandom, 1'b0, 1'b1, 1'b0);
    host_read();
    for (int n = 0; n < 3; n++)  // glitches on idle and data bits
    begin
      set_format(1'b1, n == 1, 1'b1);
      send_frame($urandom, 1'b0, 1'b1, 1'b1);
      host_read();
    end

    repeat (BIT_CLKS) @(negedge clk);
    print_summary();
    if (mismatches + other_errors + pending == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/uart_rx_checker.sv */
/*
 * uart receiver checker
 * keeps the frames sent since the last read and compares the
 * status outputs against the reference at every read
 */
`timescale 1ns/1ns
`default_nettype none

module uart_rx_checker (
  input  logic               clk,
  input  logic               aresetn,
  input  logic               frame_sent,
  input  logic [12:0]        sent_info,  // data, bit8, parity_en, odd, bad parity, stop
  input  logic               read_rx_byte,
  input  logic               clear_parity,
  input  logic               clear_framing_error,
  input  uart_rx_pkg::byte_t rx_byte,
  input  logic               receive_full,
  input  logic               overflow,
  input  logic               parity_err,
  input  logic               framing_error,
  output int                 mismatches,
  output int                 other_errors,
  output int                 pending
);

  logic [12:0] sent_q[$];
  logic [9:0]  res;        // expected byte, parity error, framing error
  logic        exp_par;
  logic        exp_frm;
  logic        reset_seen;
  logic        read_q;
  logic        clr_par_q;
  logic        clr_frm_q;

  initial
  begin
    mismatches   = 0;
    other_errors = 0;
    pending      = 0;
  end

  function automatic logic [9:0] expected_result(input logic [7:0] data, input logic b8,
                                                 input logic pe, input logic odd,
                                                 input logic inv, input logic stop);
    logic [7:0] exp_byte;
    logic       pbit;
    logic       perr;
    exp_byte = b8 ? data : {1'b0, data[6:0]};
    pbit     = (^exp_byte) ^ odd ^ inv;  // parity bit as it went on the line
    perr     = pe && (((^exp_byte) ^ pbit) != odd);
    return {exp_byte, perr, !stop};
  endfunction

  task automatic compare_value(input string name, input logic [7:0] exp,
                               input logic [7:0] act);
    if (exp !== act)
    begin
      $display("MISMATCH at %0t ns: %s expected %0h actual %0h", $time, name, exp, act);
      mismatches++;
    end
  endtask

  always @(posedge clk)
  begin
    if (!aresetn)
    begin
      reset_seen <= 1'b0;
      read_q     <= 1'b0;
      clr_par_q  <= 1'b0;
      clr_frm_q  <= 1'b0;
    end
    else
    begin
      if (!reset_seen)
      begin
        compare_value("rx_byte", 8'h00, rx_byte);  // state right after reset
        compare_value("receive_full", 8'h00, receive_full);
        compare_value("overflow", 8'h00, overflow);
        compare_value("parity_err", 8'h00, parity_err);
        compare_value("framing_error", 8'h00, framing_error);
        reset_seen <= 1'b1;
      end
      if (frame_sent)
        sent_q.push_back(sent_info);
      if (read_rx_byte && (sent_q.size() == 0))
      begin
        $display("ERROR at %0t ns: byte read but no frame was sent", $time);
        other_errors++;
      end
      else if (read_rx_byte)
      begin
        exp_par = 1'b0;
        exp_frm = 1'b0;
        // flags collect every frame since the last read and clear
        foreach (sent_q[i])
        begin
          res = expected_result(sent_q[i][12:5], sent_q[i][4], sent_q[i][3],
                                sent_q[i][2], sent_q[i][1], sent_q[i][0]);
          exp_par = exp_par | res[1];
          exp_frm = exp_frm | res[0];
        end
        res = expected_result(sent_q[0][12:5], sent_q[0][4], sent_q[0][3],
                              sent_q[0][2], sent_q[0][1], sent_q[0][0]);
        compare_value("receive_full", 8'h01, receive_full);
        compare_value("rx_byte", res[9:2], rx_byte);  // oldest byte is kept
        compare_value("overflow", sent_q.size() > 1, overflow);
        compare_value("parity_err", exp_par, parity_err);
        compare_value("framing_error", exp_frm, framing_error);
        sent_q.delete();
      end
      if (read_q)
      begin
        compare_value("receive_full after read", 8'h00, receive_full);
        compare_value("overflow after read", 8'h00, overflow);
      end
      if (clr_par_q)
        compare_value("parity_err after clear", 8'h00, parity_err);
      if (clr_frm_q)
        compare_value("framing_error after clear", 8'h00, framing_error);
      read_q    <= read_rx_byte;
      clr_par_q <= clear_parity;
      clr_frm_q <= clear_framing_error;
    end
    pending = sent_q.size();
  end

endmodule

`default_nettype wire

/* files.f */
common/uart_rx_pkg.sv
common/rx_frame_if.sv
verilog/rx_filter.sv
rx_framer/rx_framer.sv
verilog/rx_status.sv
verilog/uart_rx.sv
dv/uart_rx_checker.sv
dv/tb_uart_rx.sv

/* rx_framer/rx_framer.sv */
/*
 * uart receive framer
 * start bit detection, bit timing, data shift register and parity check
 * hands each finished frame to the status block over rx_frame_if
 */
`timescale 1ns/1ns
`default_nettype none

module rx_framer #(
  parameter int OVERSAMPLE = uart_rx_pkg::OVERSAMPLE_DEFAULT
) (
  input  logic       clk,
  input  logic       aresetn,
  input  logic       baud_tick,
  input  logic       rx_filtered,
  input  logic       bit8,        // 1: 8 data bits, 0: 7 data bits
  input  logic       parity_en,
  input  logic       odd_n_even,  // 1: odd parity, 0: even parity
  rx_frame_if.framer frame
);

  // counter also has to reach the wait limit for small ratios
  localparam int CNT_W = $clog2(OVERSAMPLE + 8);

  localparam logic [CNT_W-1:0] HALF_LAST  = CNT_W'(OVERSAMPLE / 2 - 1);
  localparam logic [CNT_W-1:0] BIT_LAST   = CNT_W'(OVERSAMPLE - 1);
  localparam logic [CNT_W-1:0] STOP_CHECK = CNT_W'(OVERSAMPLE - 2);
  localparam logic [CNT_W-1:0] WAIT_LAST  = CNT_W'(5);  // six ticks in wait

  uart_rx_pkg::rx_state_e state;
  logic [CNT_W-1:0]       tick_cnt;     // ticks within the current bit

  uart_rx_pkg::bit_cnt_t  bit_cnt;      // bits taken so far
  uart_rx_pkg::bit_cnt_t  last_bit;     // bits expected, latched at start
  uart_rx_pkg::bit_cnt_t  bit_cnt_nxt;
  logic                   bit8_q;
  logic                   par_en_q;
  logic                   par_acc;      // xor of data and parity bits
  logic [8:0]             shift;        // newest bit enters at the top

  logic                   start_ok;
  logic                   sample_now;
  logic                   last_sample;
  logic                   byte_done_q;
  logic                   stop_bad_q;
  uart_rx_pkg::byte_t     aligned;

  assign start_ok    = baud_tick && (state == uart_rx_pkg::RX_IDLE) &&
                       !rx_filtered && (tick_cnt == HALF_LAST);
  assign sample_now  = baud_tick && (state == uart_rx_pkg::RX_DATA) &&
                       (tick_cnt == BIT_LAST);
  assign bit_cnt_nxt = uart_rx_pkg::bit_cnt_t'(bit_cnt + 4'd1);
  assign last_sample = sample_now && (bit_cnt_nxt == last_bit);

  // --------------------
  // state machine
  // --------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state    <= uart_rx_pkg::RX_IDLE;
      tick_cnt <= '0;
    end
    else if (baud_tick)
    begin
      case (state)
        uart_rx_pkg::RX_IDLE:
        begin
          if (rx_filtered)
          begin
            tick_cnt <= '0;  // line high, restart the search
          end
          else if (tick_cnt == HALF_LAST)
          begin
            state    <= uart_rx_pkg::RX_DATA;  // middle of start bit
            tick_cnt <= '0;
          end
          else
          begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        uart_rx_pkg::RX_DATA:
        begin
          if (tick_cnt == BIT_LAST)
          begin
            tick_cnt <= '0;
            if (bit_cnt_nxt == last_bit)
            begin
              state <= uart_rx_pkg::RX_STOP;
            end
          end
          else
          begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        uart_rx_pkg::RX_STOP:
        begin
          if (tick_cnt == BIT_LAST)
          begin
            state    <= uart_rx_pkg::RX_WAIT;
            tick_cnt <= '0;
          end
          else
          begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        uart_rx_pkg::RX_WAIT:
        begin
          // a low stop bit may hold the line down, give up after six ticks
          if (rx_filtered || (tick_cnt == WAIT_LAST))
          begin
            state    <= uart_rx_pkg::RX_IDLE;
            tick_cnt <= '0;
          end
          else
          begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        default:
        begin
          state    <= uart_rx_pkg::RX_IDLE;
          tick_cnt <= '0;
        end
      endcase
    end
  end

  // --------------------
  // frame format, bit count and parity
  // --------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      bit8_q   <= 1'b1;
      par_en_q <= 1'b0;
      last_bit <= 4'd8;
      bit_cnt  <= '0;
      par_acc  <= 1'b0;
    end
    else if (start_ok)
    begin
      bit8_q   <= bit8;
      par_en_q <= parity_en;
      last_bit <= uart_rx_pkg::bit_cnt_t'(4'd7 + {3'b000, bit8} + {3'b000, parity_en});
      bit_cnt  <= '0;
      par_acc  <= 1'b0;
    end
    else if (sample_now)
    begin
      bit_cnt <= bit_cnt_nxt;
      par_acc <= par_acc ^ rx_filtered;
    end
  end

  // lsb arrives first and ends up lowest once all bits are in
  always_ff @(posedge clk)
  begin
    if (sample_now)
    begin
      shift <= {rx_filtered, shift[8:1]};
    end
  end

  always_comb
  begin
    case ({bit8_q, par_en_q})
      2'b00:   aligned = {1'b0, shift[8:2]};
      2'b01:   aligned = {1'b0, shift[7:1]};  // parity in shift[8]
      2'b10:   aligned = shift[8:1];
      default: aligned = shift[7:0];          // parity in shift[8]
    endcase
  end

  // output pulses, one clock after the sampling tick
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      byte_done_q <= 1'b0;
      stop_bad_q  <= 1'b0;
    end
    else
    begin
      byte_done_q <= last_sample;
      stop_bad_q  <= baud_tick && (state == uart_rx_pkg::RX_STOP) &&
                     (tick_cnt == STOP_CHECK) && !rx_filtered;
    end
  end

  assign frame.byte_done  = byte_done_q;
  assign frame.data       = aligned;
  assign frame.parity_bad = par_en_q & (par_acc ^ odd_n_even);  // odd wants xor of 1
  assign frame.stop_bad   = stop_bad_q;

  // --------------------
  // assertions
  // --------------------
  a_done_single: assert property (@(posedge clk) disable iff (!aresetn)
    frame.byte_done |=> !frame.byte_done);

  a_bit_cnt_range: assert property (@(posedge clk) disable iff (!aresetn)
    bit_cnt <= last_bit);

  a_state_legal: assert property (@(posedge clk) disable iff (!aresetn)
    state inside {uart_rx_pkg::RX_IDLE, uart_rx_pkg::RX_DATA,
                  uart_rx_pkg::RX_STOP, uart_rx_pkg::RX_WAIT});

endmodule

`default_nettype wire

/* verilog/rx_filter.sv */
/*
 * receive line glitch filter
 * three-sample majority vote taken on each oversampling tick
 */
`timescale 1ns/1ns
`default_nettype none

module rx_filter (
  input  logic clk,
  input  logic aresetn,
  input  logic baud_tick,    // oversampling strobe
  input  logic rx,           // raw serial line
  output logic rx_filtered
);

  logic [2:0] samples;  // newest sample in bit 2

  // history starts all ones, an idle line reads high
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      samples <= 3'b111;
    end
    else if (baud_tick)
    begin
      samples <= {rx, samples[2:1]};
    end
  end

  // -------------------
  // majority voter
  // -------------------
  // any two of three agreeing win, so a single-tick glitch is dropped
  assign rx_filtered = (samples[0] & samples[1]) |
                       (samples[1] & samples[2]) |
                       (samples[0] & samples[2]);

endmodule

`default_nettype wire

/* verilog/rx_status.sv */
/*
 * uart receive status
 * holds the received byte and the full, overflow, parity and
 * framing flags until the host reads or clears them
 */
`timescale 1ns/1ns
`default_nettype none

module rx_status (
  input  logic               clk,
  input  logic               aresetn,
  input  logic               read_rx_byte,
  input  logic               clear_parity,
  input  logic               clear_framing_error,
  rx_frame_if.status         frame,
  output uart_rx_pkg::byte_t rx_byte,
  output logic               receive_full,
  output logic               overflow,
  output logic               parity_err,
  output logic               framing_error
);

  // --------------------
  // byte register, full and overflow
  // --------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rx_byte      <= '0;
      receive_full <= 1'b0;
      overflow     <= 1'b0;
    end
    else
    begin
      // an unread byte is kept, the new one is lost
      if (frame.byte_done && !receive_full)
      begin
        rx_byte <= frame.data;
      end

      if (read_rx_byte)
      begin
        receive_full <= 1'b0;  // read wins
        overflow     <= 1'b0;
      end
      else if (frame.byte_done)
      begin
        if (receive_full)
        begin
          overflow <= 1'b1;
        end
        else
        begin
          receive_full <= 1'b1;
        end
      end
    end
  end

  // --------------------
  // error flags
  // --------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      parity_err    <= 1'b0;
      framing_error <= 1'b0;
    end
    else
    begin
      if (clear_parity)
      begin
        parity_err <= 1'b0;  // clear wins over a new error
      end
      else if (frame.byte_done && frame.parity_bad)
      begin
        parity_err <= 1'b1;
      end

      if (frame.stop_bad)
      begin
        framing_error <= 1'b1;  // here a new error wins
      end
      else if (clear_framing_error)
      begin
        framing_error <= 1'b0;
      end
    end
  end

  a_overflow_when_full: assert property (@(posedge clk) disable iff (!aresetn)
    $rose(overflow) |-> $past(receive_full));

endmodule

`default_nettype wire

/* verilog/uart_rx.sv */
/*
 * uart receiver top level
 * glitch filter, framer and status block in series
 */
`timescale 1ns/1ns
`default_nettype none

module uart_rx #(
  parameter int OVERSAMPLE = uart_rx_pkg::OVERSAMPLE_DEFAULT  // ticks per bit
) (
  input  logic               clk,
  input  logic               aresetn,
  input  logic               baud_tick,
  input  logic               rx,
  input  logic               bit8,
  input  logic               parity_en,
  input  logic               odd_n_even,
  input  logic               read_rx_byte,
  input  logic               clear_parity,
  input  logic               clear_framing_error,
  output uart_rx_pkg::byte_t rx_byte,
  output logic               receive_full,
  output logic               overflow,
  output logic               parity_err,
  output logic               framing_error
);

  logic rx_filtered;  // majority-voted line

  rx_frame_if frame_if ();

  rx_filter u_filter (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .rx          (rx),
    .rx_filtered (rx_filtered)
  );

  rx_framer #(
    .OVERSAMPLE (OVERSAMPLE)
  ) u_framer (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .rx_filtered (rx_filtered),
    .bit8        (bit8),
    .parity_en   (parity_en),
    .odd_n_even  (odd_n_even),
    .frame       (frame_if.framer)
  );

  rx_status u_status (
    .clk                 (clk),
    .aresetn             (aresetn),
    .read_rx_byte        (read_rx_byte),
    .clear_parity        (clear_parity),
    .clear_framing_error (clear_framing_error),
    .frame               (frame_if.status),
    .rx_byte             (rx_byte),
    .receive_full        (receive_full),
    .overflow            (overflow),
    .parity_err          (parity_err),
    .framing_error       (framing_error)
  );

endmodule

`default_nettype wire
